//--- hw/rvIsaPkg.sv
`default_nettype none

package rvIsaPkg;

	typedef enum logic [6:0] {
		OP     = 7'b0110011,
		OP_IMM = 7'b0010011,
		LUI    = 7'b0110111,
		AUIPC  = 7'b0010111,
		JAL    = 7'b1101111,
		JALR   = 7'b1100111,
		BRANCH = 7'b1100011,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		SYSTEM = 7'b1110011
	} opcodeT;

	// alu funct3, shared by register and immediate forms
	localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
	localparam logic [2:0] FUNCT3_SLL     = 3'b001;
	localparam logic [2:0] FUNCT3_SLT     = 3'b010;
	localparam logic [2:0] FUNCT3_SLTU    = 3'b011;
	localparam logic [2:0] FUNCT3_XOR     = 3'b100;
	localparam logic [2:0] FUNCT3_SRL_SRA = 3'b101;
	localparam logic [2:0] FUNCT3_OR      = 3'b110;
	localparam logic [2:0] FUNCT3_AND     = 3'b111;

	localparam logic [2:0] FUNCT3_BEQ = 3'b000;
	localparam logic [2:0] FUNCT3_BNE = 3'b001;
	localparam logic [2:0] FUNCT3_BLT = 3'b100;
	localparam logic [2:0] FUNCT3_BGE = 3'b101;

	localparam logic [2:0] FUNCT3_LW = 3'b010;
	localparam logic [2:0] FUNCT3_SW = 3'b010;

	// selects SUB and SRA
	localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

	localparam logic [31:0] EBREAK_WORD = 32'h00100073;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		opcodeT     opcode;
	} rTypeT;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		opcodeT      opcode;
	} iTypeT;

	typedef struct packed {
		logic [6:0] immHi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] immLo;
		opcodeT     opcode;
	} sTypeT;

	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		opcodeT     opcode;
	} bTypeT;

	typedef struct packed {
		logic [19:0] imm31_12;
		logic [4:0]  rd;
		opcodeT      opcode;
	} uTypeT;

	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10_1;
		logic       imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		opcodeT     opcode;
	} jTypeT;

	typedef union packed {
		rTypeT r;
		iTypeT i;
		sTypeT s;
		bTypeT b;
		uTypeT u;
		jTypeT j;
	} instrT;

endpackage

`default_nettype wire

//--- hw/corePkg.sv
`default_nettype none

package corePkg;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA
	} aluOpT;

	typedef enum logic [1:0] {
		WB_ALU,
		WB_LOAD,
		WB_PC4,
		WB_IMM
	} wbSelT;

	typedef struct packed {
		aluOpT      aluOp;
		logic       srcAPc;
		logic       srcBImm;
		logic       regWrite;
		wbSelT      wbSel;
		logic       memRead;
		logic       memWrite;
		logic       branch;
		logic       branchInvert;
		logic       jump;
		logic       jumpReg;
		logic       halt;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
	} ctrlT;

	// wishbone classic master side
	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [3:0]  sel;
		logic [31:0] adr;
		logic [31:0] dat;
	} wbReqT;

	typedef struct packed {
		logic        ack;
		logic [31:0] dat;
	} wbRspT;

	typedef enum logic [1:0] {
		FETCH,
		EXECUTE,
		MEMORY,
		HALTED
	} seqStateT;

endpackage

`default_nettype wire

//--- hw/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  wire corePkg::aluOpT op,
	input  wire logic [31:0]    srcA,
	input  wire logic [31:0]    srcB,
	input  wire logic           branchInvert,
	output logic [31:0]         result,
	output logic                takeBranch
);

	logic lessSigned;
	logic lessUnsigned;
	logic cond;

	assign lessSigned = $signed(srcA) < $signed(srcB);
	assign lessUnsigned = srcA < srcB;

	always_comb begin
		case (op)
			corePkg::ALU_ADD:  result = srcA + srcB;
			corePkg::ALU_SUB:  result = srcA - srcB;
			corePkg::ALU_AND:  result = srcA & srcB;
			corePkg::ALU_OR:   result = srcA | srcB;
			corePkg::ALU_XOR:  result = srcA ^ srcB;
			corePkg::ALU_SLT:  result = {31'b0, lessSigned};
			corePkg::ALU_SLTU: result = {31'b0, lessUnsigned};
			corePkg::ALU_SLL:  result = srcA << srcB[4:0];
			corePkg::ALU_SRL:  result = srcA >> srcB[4:0];
			corePkg::ALU_SRA:  result = $unsigned($signed(srcA) >>> srcB[4:0]);
			default:           result = '0;
		endcase
	end

	// branch condition follows the compare the decoder picked
	always_comb begin
		case (op)
			corePkg::ALU_SUB:  cond = (srcA == srcB);
			corePkg::ALU_SLT:  cond = lessSigned;
			corePkg::ALU_SLTU: cond = lessUnsigned;
			default:           cond = 1'b0;
		endcase
	end

	assign takeBranch = cond ^ branchInvert;

endmodule

`default_nettype wire

//--- hw/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile #(
	parameter int regCount = 32
) (
	input  wire logic        clk,
	input  wire logic        rst,
	input  wire logic        writeEn,
	input  wire logic [4:0]  rs1,
	input  wire logic [4:0]  rs2,
	input  wire logic [4:0]  rd,
	input  wire logic [31:0] writeData,
	output logic [31:0]      readData1,
	output logic [31:0]      readData2
);

	localparam int idxWidth = $clog2(regCount);

	logic [31:0] regs [regCount];
	logic [idxWidth-1:0] rdIdx;
	logic [idxWidth-1:0] rs1Idx;
	logic [idxWidth-1:0] rs2Idx;

	// rv32e drops the top index bit
	assign rdIdx = rd[idxWidth-1:0];
	assign rs1Idx = rs1[idxWidth-1:0];
	assign rs2Idx = rs2[idxWidth-1:0];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int k = 0; k < regCount; k++) begin
				regs[k] <= '0;
			end
		end else if (writeEn && rdIdx != '0) begin
			regs[rdIdx] <= writeData;
		end
	end

	assign readData1 = regs[rs1Idx];
	assign readData2 = regs[rs2Idx];

	x0ReadsZero: assert property (@(posedge clk) disable iff (rst)
		(rs1 == 5'd0 |-> readData1 == '0) and (rs2 == 5'd0 |-> readData2 == '0));

endmodule

`default_nettype wire

//--- hw/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
	input  wire rvIsaPkg::instrT instr,
	output corePkg::ctrlT        ctrl,
	output logic [31:0]          imm
);

	logic [31:0] iImm;
	logic [31:0] sImm;
	logic [31:0] bImm;
	logic [31:0] uImm;
	logic [31:0] jImm;
	logic shiftRight;

	function automatic corePkg::aluOpT functToAluOp(input logic [2:0] funct3, input logic alt);
		corePkg::aluOpT op;
		case (funct3)
			rvIsaPkg::FUNCT3_ADD_SUB: op = alt ? corePkg::ALU_SUB : corePkg::ALU_ADD;
			rvIsaPkg::FUNCT3_SLL:     op = corePkg::ALU_SLL;
			rvIsaPkg::FUNCT3_SLT:     op = corePkg::ALU_SLT;
			rvIsaPkg::FUNCT3_SLTU:    op = corePkg::ALU_SLTU;
			rvIsaPkg::FUNCT3_XOR:     op = corePkg::ALU_XOR;
			rvIsaPkg::FUNCT3_SRL_SRA: op = alt ? corePkg::ALU_SRA : corePkg::ALU_SRL;
			rvIsaPkg::FUNCT3_OR:      op = corePkg::ALU_OR;
			default:                  op = corePkg::ALU_AND;
		endcase
		return op;
	endfunction

	assign iImm = {{20{instr.i.imm[11]}}, instr.i.imm};
	assign sImm = {{20{instr.s.immHi[6]}}, instr.s.immHi, instr.s.immLo};
	assign bImm = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11, instr.b.imm10_5,
		instr.b.imm4_1, 1'b0};
	assign uImm = {instr.u.imm31_12, 12'b0};
	assign jImm = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12, instr.j.imm11,
		instr.j.imm10_1, 1'b0};

	// immediate shifts carry the sra flag where funct7 sits
	assign shiftRight = (instr.r.funct3 == rvIsaPkg::FUNCT3_SRL_SRA);

	always_comb begin
		ctrl = '0;
		ctrl.aluOp = corePkg::ALU_ADD;
		ctrl.wbSel = corePkg::WB_ALU;
		ctrl.rd = instr.r.rd;
		ctrl.rs1 = instr.r.rs1;
		ctrl.rs2 = instr.r.rs2;
		imm = '0;
		case (instr.r.opcode)
			rvIsaPkg::OP: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluOp = functToAluOp(instr.r.funct3,
					instr.r.funct7 == rvIsaPkg::FUNCT7_ALT);
			end
			rvIsaPkg::OP_IMM: begin
				ctrl.regWrite = 1'b1;
				ctrl.srcBImm = 1'b1;
				ctrl.aluOp = functToAluOp(instr.r.funct3,
					shiftRight && instr.r.funct7 == rvIsaPkg::FUNCT7_ALT);
				imm = iImm;
			end
			rvIsaPkg::LUI: begin
				ctrl.regWrite = 1'b1;
				ctrl.wbSel = corePkg::WB_IMM;
				imm = uImm;
			end
			rvIsaPkg::AUIPC: begin
				ctrl.regWrite = 1'b1;
				ctrl.srcAPc = 1'b1;
				ctrl.srcBImm = 1'b1;
				imm = uImm;
			end
			rvIsaPkg::JAL: begin
				ctrl.regWrite = 1'b1;
				ctrl.wbSel = corePkg::WB_PC4;
				ctrl.jump = 1'b1;
				imm = jImm;
			end
			rvIsaPkg::JALR: begin
				ctrl.regWrite = 1'b1;
				ctrl.wbSel = corePkg::WB_PC4;
				ctrl.jumpReg = 1'b1;
				ctrl.srcBImm = 1'b1;
				imm = iImm;
			end
			rvIsaPkg::BRANCH: begin
				imm = bImm;
				case (instr.b.funct3)
					rvIsaPkg::FUNCT3_BEQ, rvIsaPkg::FUNCT3_BNE: begin
						ctrl.branch = 1'b1;
						ctrl.aluOp = corePkg::ALU_SUB;
						ctrl.branchInvert = (instr.b.funct3 == rvIsaPkg::FUNCT3_BNE);
					end
					rvIsaPkg::FUNCT3_BLT, rvIsaPkg::FUNCT3_BGE: begin
						ctrl.branch = 1'b1;
						ctrl.aluOp = corePkg::ALU_SLT;
						ctrl.branchInvert = (instr.b.funct3 == rvIsaPkg::FUNCT3_BGE);
					end
					default: begin
						ctrl.branch = 1'b0;
					end
				endcase
			end
			rvIsaPkg::LOAD: begin
				if (instr.i.funct3 == rvIsaPkg::FUNCT3_LW) begin
					ctrl.memRead = 1'b1;
					ctrl.regWrite = 1'b1;
					ctrl.wbSel = corePkg::WB_LOAD;
					ctrl.srcBImm = 1'b1;
					imm = iImm;
				end
			end
			rvIsaPkg::STORE: begin
				if (instr.s.funct3 == rvIsaPkg::FUNCT3_SW) begin
					ctrl.memWrite = 1'b1;
					ctrl.srcBImm = 1'b1;
					imm = sImm;
				end
			end
			rvIsaPkg::SYSTEM: begin
				ctrl.halt = (instr == rvIsaPkg::EBREAK_WORD);
			end
			default: begin
				// unknown opcode retires as a no-op
				ctrl.regWrite = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- hw/programCounter.sv
`timescale 1ns/1ps
`default_nettype none

module programCounter #(
	parameter logic [31:0] resetVector = 32'h0
) (
	input  wire logic          clk,
	input  wire logic          rst,
	input  wire logic          advance,
	input  wire corePkg::ctrlT ctrl,
	input  wire logic          takeBranch,
	input  wire logic [31:0]   imm,
	input  wire logic [31:0]   aluResult,
	output logic [31:0]        pc,
	output logic [31:0]        pcPlus4,
	output logic [31:0]        retired
);

	logic [31:0] nextPc;

	assign pcPlus4 = pc + 32'd4;

	always_comb begin
		if (ctrl.jumpReg) begin
			nextPc = {aluResult[31:1], 1'b0};
		end else if (ctrl.jump || (ctrl.branch && takeBranch)) begin
			nextPc = pc + imm;
		end else begin
			nextPc = pcPlus4;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= resetVector;
			retired <= '0;
		end else if (advance) begin
			pc <= nextPc;
			retired <= retired + 32'd1;
		end
	end

	pcWordAligned: assert property (@(posedge clk) disable iff (rst)
		pc[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- hw/coreSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module coreSequencer #(
	parameter logic [31:0] resetVector = 32'h0
) (
	input  wire logic             clk,
	input  wire logic             rst,
	output corePkg::wbReqT        wbReq,
	input  wire corePkg::wbRspT   wbRsp,
	input  wire corePkg::ctrlT    ctrl,
	input  wire logic [31:0]      pc,
	input  wire logic [31:0]      aluResult,
	input  wire logic [31:0]      storeData,
	output rvIsaPkg::instrT       instr,
	output logic [31:0]           loadData,
	output logic                  advance,
	output logic                  regWriteEn,
	output logic                  halted
);

	corePkg::seqStateT state;
	logic reqActive;
	logic memAccess;

	assign memAccess = ctrl.memRead | ctrl.memWrite;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= corePkg::FETCH;
			reqActive <= 1'b0;
		end else begin
			case (state)
				corePkg::FETCH: begin
					if (!reqActive) begin
						reqActive <= 1'b1;
					end else if (wbRsp.ack) begin
						reqActive <= 1'b0;
						state <= corePkg::EXECUTE;
					end
				end
				corePkg::EXECUTE: begin
					if (ctrl.halt) begin
						state <= corePkg::HALTED;
					end else if (memAccess) begin
						reqActive <= 1'b1;
						state <= corePkg::MEMORY;
					end else begin
						// next fetch goes out right away at the new pc
						reqActive <= 1'b1;
						state <= corePkg::FETCH;
					end
				end
				corePkg::MEMORY: begin
					if (wbRsp.ack) begin
						reqActive <= 1'b0;
						state <= corePkg::FETCH;
					end
				end
				default: begin
					state <= corePkg::HALTED;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == corePkg::FETCH && reqActive && wbRsp.ack) begin
			instr <= wbRsp.dat;
		end
	end

	always_comb begin
		wbReq.cyc = reqActive;
		wbReq.stb = reqActive;
		wbReq.we = (state == corePkg::MEMORY) && ctrl.memWrite;
		wbReq.sel = 4'hf;
		wbReq.adr = (state == corePkg::MEMORY) ? aluResult : pc;
		wbReq.dat = storeData;
	end

	// regFile samples the slave data on the ack edge itself
	assign loadData = wbRsp.dat;

	assign advance = (state == corePkg::EXECUTE && !ctrl.halt && !memAccess)
		|| (state == corePkg::MEMORY && wbRsp.ack);
	assign regWriteEn = (state == corePkg::EXECUTE && !ctrl.halt && !memAccess && ctrl.regWrite)
		|| (state == corePkg::MEMORY && wbRsp.ack && ctrl.memRead);
	assign halted = (state == corePkg::HALTED);

	stbNeedsCyc: assert property (@(posedge clk) disable iff (rst)
		wbReq.stb |-> wbReq.cyc);

	reqHeldUntilAck: assert property (@(posedge clk) disable iff (rst)
		wbReq.cyc && !wbRsp.ack |=> wbReq.cyc && wbReq.stb && $stable(wbReq.adr)
			&& $stable(wbReq.we) && $stable(wbReq.dat));

	cycDropsAfterAck: assert property (@(posedge clk) disable iff (rst)
		wbReq.cyc && wbRsp.ack |=> !wbReq.cyc);

	// first fetch after reset goes out at the reset vector
	firstFetchAtResetVector: assert property (@(posedge clk)
		rst ##1 !rst |=> wbReq.cyc && wbReq.adr == resetVector);

endmodule

`default_nettype wire

//--- hw/rvCore.sv
`timescale 1ns/1ps
`default_nettype none

module rvCore #(
	parameter logic [31:0] resetVector = 32'h0,
	parameter int          regCount = 32
) (
	input  wire logic           clk,
	input  wire logic           rst,
	output corePkg::wbReqT      wbReq,
	input  wire corePkg::wbRspT wbRsp,
	output logic                halted,
	output logic [31:0]         retired
);

	rvIsaPkg::instrT instr;
	corePkg::ctrlT ctrl;
	logic [31:0] imm;
	logic [31:0] pc;
	logic [31:0] pcPlus4;
	logic [31:0] readData1;
	logic [31:0] readData2;
	logic [31:0] srcA;
	logic [31:0] srcB;
	logic [31:0] aluResult;
	logic [31:0] loadData;
	logic [31:0] writeData;
	logic takeBranch;
	logic advance;
	logic regWriteEn;

	assign srcA = ctrl.srcAPc ? pc : readData1;
	assign srcB = ctrl.srcBImm ? imm : readData2;

	always_comb begin
		case (ctrl.wbSel)
			corePkg::WB_LOAD: writeData = loadData;
			corePkg::WB_PC4:  writeData = pcPlus4;
			corePkg::WB_IMM:  writeData = imm;
			default:          writeData = aluResult;
		endcase
	end

	coreSequencer #(
		.resetVector(resetVector)
	) u_coreSequencer (
		.clk       (clk),
		.rst       (rst),
		.wbReq     (wbReq),
		.wbRsp     (wbRsp),
		.ctrl      (ctrl),
		.pc        (pc),
		.aluResult (aluResult),
		.storeData (readData2),
		.instr     (instr),
		.loadData  (loadData),
		.advance   (advance),
		.regWriteEn(regWriteEn),
		.halted    (halted)
	);

	programCounter #(
		.resetVector(resetVector)
	) u_programCounter (
		.clk       (clk),
		.rst       (rst),
		.advance   (advance),
		.ctrl      (ctrl),
		.takeBranch(takeBranch),
		.imm       (imm),
		.aluResult (aluResult),
		.pc        (pc),
		.pcPlus4   (pcPlus4),
		.retired   (retired)
	);

	instrDecoder u_instrDecoder (
		.instr(instr),
		.ctrl (ctrl),
		.imm  (imm)
	);

	regFile #(
		.regCount(regCount)
	) u_regFile (
		.clk      (clk),
		.rst      (rst),
		.writeEn  (regWriteEn),
		.rs1      (ctrl.rs1),
		.rs2      (ctrl.rs2),
		.rd       (ctrl.rd),
		.writeData(writeData),
		.readData1(readData1),
		.readData2(readData2)
	);

	alu u_alu (
		.op          (ctrl.aluOp),
		.srcA        (srcA),
		.srcB        (srcB),
		.branchInvert(ctrl.branchInvert),
		.result      (aluResult),
		.takeBranch  (takeBranch)
	);

endmodule

`default_nettype wire

//--- verification/tbClockGen.sv
`timescale 1ns/1ps
`default_nettype none

module tbClockGen (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		rst = 1'b1;
	end

	always #5 clk = ~clk;

	// holds rst high across 8 rising edges
	task automatic applyReset();
		@(posedge clk);
		rst <= 1'b1;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
	endtask

endmodule

`default_nettype wire

//--- verification/wbMemModel.sv
`timescale 1ns/1ps
`default_nettype none

module wbMemModel (
	input  wire logic           clk,
	input  wire logic           rst,
	input  wire corePkg::wbReqT wbReq,
	output corePkg::wbRspT      wbRsp
);

	logic [31:0] mem [1024];
	logic [31:0] logAdr [64];
	logic [31:0] logDat [64];
	int logCount = 0;
	logic forceMax = 1'b0;
	int waitCount;
	int delay;

	task automatic clearMemory();
		for (int k = 0; k < 1024; k++) begin
			mem[k] = 32'ha5000000 | (32'(k) << 2);
		end
		logCount = 0;
	endtask

	task automatic writeWord(input logic [31:0] adr, input logic [31:0] data);
		mem[adr[11:2]] = data;
	endtask

	task automatic setMaxDelay(input logic on);
		forceMax = on;
	endtask

	always @(posedge clk) begin
		if (rst) begin
			wbRsp.ack <= 1'b0;
			wbRsp.dat <= '0;
			waitCount <= 0;
			delay <= int'($urandom % 4);
		end else if (wbRsp.ack) begin
			wbRsp.ack <= 1'b0;
			waitCount <= 0;
		end else if (wbReq.cyc && wbReq.stb) begin
			if (waitCount >= (forceMax ? 3 : delay)) begin
				wbRsp.ack <= 1'b1;
				if (wbReq.we) begin
					mem[wbReq.adr[11:2]] = wbReq.dat;
					if (logCount < 64) begin
						logAdr[logCount] = wbReq.adr;
						logDat[logCount] = wbReq.dat;
					end
					logCount = logCount + 1;
				end else begin
					wbRsp.dat <= mem[wbReq.adr[11:2]];
				end
				delay <= int'($urandom % 4);
			end else begin
				waitCount <= waitCount + 1;
			end
		end
	end

endmodule

`default_nettype wire

//--- verification/tbRvCore.sv
`timescale 1ns/1ps
`default_nettype none

module tbRvCore;

	// executed instructions over all programs: 0 + 45 + 11 + 27 + 45
	localparam int instrTotal = 128;
	localparam int testCount = 5;
	localparam int cycleLimit = instrTotal * 10 + testCount * (8 + 20 + 4);
	localparam logic [31:0] dataBase = 32'h400;

	logic clk;
	logic rst;
	corePkg::wbReqT wbReq;
	corePkg::wbRspT wbRsp;
	logic halted;
	logic [31:0] retired;

	logic [31:0] prog[$];
	logic [31:0] expAdr[$];
	logic [31:0] expDat[$];
	int storeOff;
	int errors = 0;
	int failedTests = 0;
	int testErrStart;
	int cycleCount = 0;

	tbClockGen u_clk (.clk(clk), .rst(rst));

	wbMemModel u_mem (.clk(clk), .rst(rst), .wbReq(wbReq), .wbRsp(wbRsp));

	rvCore #(
		.resetVector(32'h0),
		.regCount   (32)
	) u_rvCore (
		.clk    (clk),
		.rst    (rst),
		.wbReq  (wbReq),
		.wbRsp  (wbRsp),
		.halted (halted),
		.retired(retired)
	);

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("timeout: run went past %0d cycles", cycleLimit);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, rvIsaPkg::OP};
	endfunction

	function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, rvIsaPkg::FUNCT3_SW, imm[4:0], rvIsaPkg::STORE};
	endfunction

	function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rvIsaPkg::BRANCH};
	endfunction

	function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rvIsaPkg::JAL};
	endfunction

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("error %s got %h expected %h", name, got, expected);
			errors++;
		end
	endtask

	task automatic startTest();
		testErrStart = errors;
		prog.delete();
		expAdr.delete();
		expDat.delete();
		storeOff = 0;
	endtask

	task automatic endTest(input string name);
		if (errors == testErrStart) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: failed with %0d errors", name, errors - testErrStart);
			failedTests++;
		end
	endtask

	task automatic emit(input logic [31:0] word);
		prog.push_back(word);
	endtask

	// one op plus a store of its rd to the next data slot
	task automatic opAndStore(input logic [31:0] word, input logic [4:0] rd,
		input logic [31:0] value);
		emit(word);
		emit(encS(12'(storeOff), rd, 5'd10));
		expAdr.push_back(dataBase + 32'(storeOff));
		expDat.push_back(value);
		storeOff += 4;
	endtask

	task automatic expectStore(input logic [31:0] adr, input logic [31:0] value);
		expAdr.push_back(adr);
		expDat.push_back(value);
	endtask

	task automatic loadProgram();
		u_mem.clearMemory();
		foreach (prog[k]) begin
			u_mem.writeWord(32'(k) << 2, prog[k]);
		end
	endtask

	// budget of 10 cycles per executed instruction plus the final ebreak
	task automatic waitHalted(input string name, input int instrCount);
		int n;
		int limit;
		n = 0;
		limit = instrCount * 10 + 20;
		while (!halted && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (!halted) begin
			$display("test %s: the core never halted", name);
			errors++;
		end
	endtask

	// halted must stay up with the bus idle
	task automatic checkHaltState(input int expRetired);
		int bad;
		bad = 0;
		repeat (20) begin
			@(negedge clk);
			if (!halted || wbReq.cyc) begin
				bad++;
			end
		end
		if (bad != 0) begin
			$display("halt was not held with cyc low for %0d of 20 cycles", bad);
			errors++;
		end
		checkValue("retired", retired, 32'(expRetired));
	endtask

	task automatic checkStores();
		checkValue("storeCount", 32'(u_mem.logCount), 32'(expAdr.size()));
		foreach (expAdr[k]) begin
			if (k < u_mem.logCount) begin
				checkValue($sformatf("store%0d.adr", k), u_mem.logAdr[k], expAdr[k]);
				checkValue($sformatf("store%0d.dat", k), u_mem.logDat[k], expDat[k]);
			end
		end
	endtask

	task automatic runResetTest();
		int n;
		startTest();
		emit(rvIsaPkg::EBREAK_WORD);
		loadProgram();
		u_clk.applyReset();
		@(negedge clk);
		checkValue("wbReq.cyc", 32'(wbReq.cyc), 32'd0);
		checkValue("halted", 32'(halted), 32'd0);
		checkValue("retired", retired, 32'd0);
		n = 0;
		while (!wbReq.cyc && n < 4) begin
			@(negedge clk);
			n++;
		end
		checkValue("wbReq.cyc", 32'(wbReq.cyc), 32'd1);
		checkValue("wbReq.stb", 32'(wbReq.stb), 32'd1);
		checkValue("wbReq.we", 32'(wbReq.we), 32'd0);
		checkValue("wbReq.sel", 32'(wbReq.sel), 32'hf);
		checkValue("wbReq.adr", wbReq.adr, 32'h0);
		waitHalted("reset", 0);
		checkHaltState(0);
		endTest("reset");
	endtask

	task automatic buildAluProgram();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] pcNow;
		a = 32'hffffffec;
		b = 32'd7;
		emit(encI(12'h400, 5'd0, 3'b000, 5'd10, rvIsaPkg::OP_IMM));
		emit(encI(12'hfec, 5'd0, 3'b000, 5'd1, rvIsaPkg::OP_IMM));
		emit(encI(12'h007, 5'd0, 3'b000, 5'd2, rvIsaPkg::OP_IMM));
		opAndStore(encR(7'h00, 5'd2, 5'd1, rvIsaPkg::FUNCT3_ADD_SUB, 5'd3), 5'd3, a + b);
		opAndStore(encR(7'h20, 5'd2, 5'd1, rvIsaPkg::FUNCT3_ADD_SUB, 5'd4), 5'd4, a - b);
		opAndStore(encR(7'h00, 5'd2, 5'd1, rvIsaPkg::FUNCT3_AND, 5'd5), 5'd5, a & b);
		opAndStore(encR(7'h00, 5'd2, 5'd1, rvIsaPkg::FUNCT3_OR, 5'd6), 5'd6, a | b);
		opAndStore(encR(7'h00, 5'd2, 5'd1, rvIsaPkg::FUNCT3_XOR, 5'd7), 5'd7, a ^ b);
		// a negative, so signed and unsigned compares disagree
		opAndStore(encR(7'h00, 5'd2, 5'd1, rvIsaPkg::FUNCT3_SLT, 5'd8), 5'd8, 32'd1);
		opAndStore(encR(7'h00, 5'd2, 5'd1, rvIsaPkg::FUNCT3_SLTU, 5'd9), 5'd9, 32'd0);
		opAndStore(encR(7'h00, 5'd2, 5'd1, rvIsaPkg::FUNCT3_SLL, 5'd11), 5'd11, a << 7);
		opAndStore(encR(7'h00, 5'd2, 5'd1, rvIsaPkg::FUNCT3_SRL_SRA, 5'd12), 5'd12, a >> 7);
		opAndStore(encR(7'h20, 5'd2, 5'd1, rvIsaPkg::FUNCT3_SRL_SRA, 5'd13), 5'd13,
			32'hffffffff);
		opAndStore(encI(12'd100, 5'd1, rvIsaPkg::FUNCT3_ADD_SUB, 5'd14, rvIsaPkg::OP_IMM),
			5'd14, a + 32'd100);
		opAndStore(encI(12'h0f0, 5'd1, rvIsaPkg::FUNCT3_XOR, 5'd15, rvIsaPkg::OP_IMM),
			5'd15, a ^ 32'h0f0);
		opAndStore(encI(12'h00f, 5'd1, rvIsaPkg::FUNCT3_OR, 5'd15, rvIsaPkg::OP_IMM),
			5'd15, a | 32'h00f);
		opAndStore(encI(12'h7f0, 5'd1, rvIsaPkg::FUNCT3_AND, 5'd15, rvIsaPkg::OP_IMM),
			5'd15, a & 32'h7f0);
		opAndStore(encI(12'hffb, 5'd1, rvIsaPkg::FUNCT3_SLT, 5'd15, rvIsaPkg::OP_IMM),
			5'd15, 32'd1);
		opAndStore(encI(12'h005, 5'd1, rvIsaPkg::FUNCT3_SLTU, 5'd15, rvIsaPkg::OP_IMM),
			5'd15, 32'd0);
		opAndStore(encI(12'h003, 5'd1, rvIsaPkg::FUNCT3_SLL, 5'd15, rvIsaPkg::OP_IMM),
			5'd15, a << 3);
		opAndStore(encI(12'h004, 5'd1, rvIsaPkg::FUNCT3_SRL_SRA, 5'd15, rvIsaPkg::OP_IMM),
			5'd15, a >> 4);
		opAndStore(encI(12'h404, 5'd1, rvIsaPkg::FUNCT3_SRL_SRA, 5'd15, rvIsaPkg::OP_IMM),
			5'd15, 32'hfffffffe);
		opAndStore(encU(20'habcde, 5'd16, rvIsaPkg::LUI), 5'd16, 32'habcde000);
		pcNow = 32'(prog.size()) << 2;
		opAndStore(encU(20'h00001, 5'd17, rvIsaPkg::AUIPC), 5'd17, pcNow + 32'h1000);
		emit(rvIsaPkg::EBREAK_WORD);
	endtask

	task automatic runAluTest();
		startTest();
		buildAluProgram();
		loadProgram();
		u_clk.applyReset();
		waitHalted("alu", prog.size() - 1);
		checkStores();
		checkHaltState(prog.size() - 1);
		endTest("alu");
	endtask

	task automatic runLoadTest();
		logic [31:0] wordA;
		logic [31:0] wordB;
		wordA = 32'h12345678;
		wordB = 32'h0f0f0f0f;
		startTest();
		emit(encI(12'h400, 5'd0, 3'b000, 5'd10, rvIsaPkg::OP_IMM));
		emit(encI(12'd0, 5'd10, rvIsaPkg::FUNCT3_LW, 5'd1, rvIsaPkg::LOAD));
		emit(encI(12'd4, 5'd10, rvIsaPkg::FUNCT3_LW, 5'd2, rvIsaPkg::LOAD));
		storeOff = 16;
		opAndStore(encR(7'h00, 5'd2, 5'd1, rvIsaPkg::FUNCT3_ADD_SUB, 5'd3), 5'd3, wordA + wordB);
		opAndStore(encR(7'h00, 5'd2, 5'd1, rvIsaPkg::FUNCT3_XOR, 5'd4), 5'd4, wordA ^ wordB);
		// x0 must ignore this write
		opAndStore(encI(12'd5, 5'd1, 3'b000, 5'd0, rvIsaPkg::OP_IMM), 5'd0, 32'd0);
		opAndStore(encR(7'h00, 5'd2, 5'd0, rvIsaPkg::FUNCT3_ADD_SUB, 5'd5), 5'd5, wordB);
		emit(rvIsaPkg::EBREAK_WORD);
		loadProgram();
		u_mem.writeWord(dataBase, wordA);
		u_mem.writeWord(dataBase + 32'd4, wordB);
		u_clk.applyReset();
		waitHalted("load", prog.size() - 1);
		checkStores();
		checkHaltState(prog.size() - 1);
		endTest("load");
	endtask

	task automatic runBranchTest();
		int count;
		logic [31:0] adr;
		startTest();
		emit(encI(12'h400, 5'd0, 3'b000, 5'd10, rvIsaPkg::OP_IMM));
		emit(encI(12'd5, 5'd0, 3'b000, 5'd1, rvIsaPkg::OP_IMM));
		emit(encS(12'd0, 5'd1, 5'd10));
		emit(encI(12'd4, 5'd10, 3'b000, 5'd10, rvIsaPkg::OP_IMM));
		emit(encI(12'hfff, 5'd1, 3'b000, 5'd1, rvIsaPkg::OP_IMM));
		emit(encB(13'h1ff4, 5'd0, 5'd1, rvIsaPkg::FUNCT3_BNE));
		// jal at 24 jumps to 40, jalr returns to 28
		emit(encJ(21'd16, 5'd5));
		emit(encS(12'd0, 5'd6, 5'd10));
		emit(encS(12'd4, 5'd5, 5'd10));
		emit(rvIsaPkg::EBREAK_WORD);
		emit(encI(12'd77, 5'd0, 3'b000, 5'd6, rvIsaPkg::OP_IMM));
		emit(encI(12'd0, 5'd5, 3'b000, 5'd0, rvIsaPkg::JALR));
		count = 2;
		adr = dataBase;
		for (int c = 5; c != 0; c--) begin
			expectStore(adr, 32'(c));
			adr += 4;
			count += 4;
		end
		expectStore(adr, 32'd77);
		expectStore(adr + 32'd4, 32'd24 + 32'd4);
		count += 5;
		loadProgram();
		u_clk.applyReset();
		waitHalted("branch", count);
		checkStores();
		checkHaltState(count);
		endTest("branch");
	endtask

	// same program and expected stores as the alu test, every ack at the longest delay
	task automatic runBackPressureTest();
		startTest();
		buildAluProgram();
		loadProgram();
		u_mem.setMaxDelay(1'b1);
		u_clk.applyReset();
		waitHalted("backpressure", prog.size() - 1);
		checkStores();
		checkHaltState(prog.size() - 1);
		u_mem.setMaxDelay(1'b0);
		endTest("backpressure");
	endtask

	initial begin
		void'($urandom(32'h93edec36));
		runResetTest();
		runAluTest();
		runLoadTest();
		runBranchTest();
		runBackPressureTest();
		$display("tests %0d, failed %0d, errors %0d", testCount, failedTests, errors);
		if (errors == 0 && failedTests == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
hw/rvIsaPkg.sv
hw/corePkg.sv
hw/alu.sv
hw/regFile.sv
hw/instrDecoder.sv
hw/programCounter.sv
hw/coreSequencer.sv
hw/rvCore.sv
verification/tbClockGen.sv
verification/wbMemModel.sv
verification/tbRvCore.sv

//--- run.sh
#!/bin/sh
# builds and runs the rvCore testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tbRvCore \
	-f build.f -o simRvCore
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/simRvCore > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "SIMULATION FAILED" sim.log; then
	exit 1
fi
if ! grep -q "SIMULATION PASSED" sim.log; then
	echo "no pass line found in sim.log"
	exit 1
fi
exit 0
